/* compile.f */
+incdir+include
verilog/eth_pkg.sv
verilog/axis_pkg.sv
verilog/eth_crc32.sv
verilog/gmii_tx_framer.sv
verilog/gmii_rx_deframer.sv
verilog/eth_mac_1g.sv
verification/tb_eth_mac_1g.sv

/* include/eth_mac_params.svh */
// Constants for the 8-bit GMII MAC; the CRC and frame lengths assume standard 802.3 frames
`ifndef ETH_MAC_PARAMS_SVH
`define ETH_MAC_PARAMS_SVH

// ########################################
// Datapath widths
// ########################################

// One byte per clock on both GMII and the host stream
`define ETH_DATA_W 8

// Width of the cfg_ifg input and of the framer counter
`define ETH_IFG_W 8

// ########################################
// Frame format
// ########################################

// Minimum frame length counted with the FCS
`define ETH_MIN_FRAME_LEN 64
`define ETH_FCS_LEN 4

// Preamble bytes sent before the delimiter
`define ETH_PREAMBLE_LEN 7
`define ETH_PREAMBLE_BYTE 8'h55
`define ETH_SFD_BYTE 8'hD5

// Reflected CRC-32 polynomial
`define ETH_CRC_POLY 32'hEDB88320
// Register value left by a good frame with its FCS folded in
`define ETH_CRC_RESIDUE 32'hDEBB20E3

`endif

/* run_sim.sh */
#!/bin/sh
# Build and run the MAC loopback testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -f compile.f --top-module tb_eth_mac_1g; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/Vtb_eth_mac_1g)
status=$?
echo "$out"

if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -q "ALL TESTS PASSED"; then
    exit 0
fi
exit 1

/* verification/tb_eth_mac_1g.sv */
// Loopback testbench on one shared clock; gmii_rx mirrors gmii_tx except for an optional bad byte
`include "eth_mac_params.svh"

module tb_eth_mac_1g
    import eth_pkg::*;
    import axis_pkg::*;
();

typedef enum {FILL_RAMP, FILL_RANDOM} fill_e;

localparam int CORRUPT_POS = 10;
localparam logic [7:0] CORRUPT_MASK = 8'h5A;
localparam int SEND_LIMIT = 200;
localparam int DONE_LIMIT = 200;

logic clk = 1'b0;
logic rst;
axis_beat_t s_axis_tx;
logic s_axis_tx_ready;
axis_beat_t m_axis_rx;
gmii_t gmii_tx;
gmii_t gmii_rx;
logic [`ETH_IFG_W-1:0] cfg_ifg;
logic tx_start_packet;
logic tx_error_underflow;
rx_status_t rx_status;

// Test table with one entry per row in each queue
string tbl_name[$];
int tbl_len[$];
fill_e tbl_fill[$];
bit tbl_corrupt[$];
int tbl_uflow[$];
int tbl_ifg[$];
bit tbl_user[$];

integer seed;
string row_name;
logic [7:0] payload[$];
logic [7:0] exp_q[$];
int value_errors = 0;
int timeout_errors = 0;
bit timed_out = 1'b0;

// Capture state filled by the monitor
logic [7:0] tx_bytes[$];
logic [7:0] rx_bytes[$];
int start_cnt, uflow_cnt, tx_er_cnt, rx_start_cnt, bad_fcs_cnt, bad_frame_cnt;
bit rx_done, rx_last_user, rx_last_valid;
bit prev_en = 1'b0;
bit seen_fall = 1'b0;
int low_run = 0;
int wire_idx = 0;
logic corrupt_on = 1'b0;

always #50 clk = ~clk;

eth_mac_1g dut_i (
    .tx_clk(clk),
    .rx_clk(clk),
    .rst(rst),
    .s_axis_tx(s_axis_tx),
    .s_axis_tx_ready(s_axis_tx_ready),
    .m_axis_rx(m_axis_rx),
    .gmii_tx(gmii_tx),
    .gmii_rx(gmii_rx),
    .cfg_ifg(cfg_ifg),
    .tx_start_packet(tx_start_packet),
    .tx_error_underflow(tx_error_underflow),
    .rx_status(rx_status)
);

// ########################################
// Loopback and monitor
// ########################################

// Index of the current wire byte within its frame counting the preamble
always @(posedge clk) begin
    if (gmii_tx.en) wire_idx <= wire_idx + 1;
    else wire_idx <= 0;
end

assign gmii_rx = '{data: gmii_tx.data ^ ((corrupt_on && wire_idx == CORRUPT_POS + 8) ?
                                         CORRUPT_MASK : 8'h00),
                   en: gmii_tx.en, er: gmii_tx.er};

always @(negedge clk) begin
    if (!rst) begin
        if (gmii_tx.en) begin
            if (!prev_en && seen_fall) begin
                assert (low_run >= int'(cfg_ifg)) else begin
                    $display("ERROR %s gap: expected at least %0d, actual %0d",
                             row_name, cfg_ifg, low_run);
                    value_errors++;
                end
            end
            tx_bytes.push_back(gmii_tx.data);
            if (gmii_tx.er) tx_er_cnt++;
        end else begin
            if (prev_en) begin
                seen_fall = 1'b1;
                low_run = 0;
            end
            low_run++;
        end
        prev_en = gmii_tx.en;
        if (tx_start_packet) start_cnt++;
        if (tx_error_underflow) uflow_cnt++;
        if (rx_status.start_packet) rx_start_cnt++;
        if (rx_status.error_bad_fcs) bad_fcs_cnt++;
        if (rx_status.error_bad_frame) bad_frame_cnt++;
        if (m_axis_rx.tvalid) rx_bytes.push_back(m_axis_rx.tdata);
        if (m_axis_rx.tlast) begin
            rx_done = 1'b1;
            rx_last_user = m_axis_rx.tuser;
            rx_last_valid = m_axis_rx.tvalid;
        end
    end
end

// ########################################
// Helpers
// ########################################

task automatic check_value(input string what, input int expected, input int actual);
    assert (expected == actual) else begin
        $display("ERROR %s %s: expected 0x%0h, actual 0x%0h", row_name, what, expected, actual);
        value_errors++;
    end
endtask

// Bit-serial reflected CRC-32 returned already inverted
function automatic logic [31:0] frame_crc(input logic [7:0] data_q[$]);
    logic [31:0] c;
    c = 32'hFFFFFFFF;
    foreach (data_q[i]) begin
        for (int b = 0; b < 8; b++) begin
            if (c[0] ^ data_q[i][b]) c = (c >> 1) ^ `ETH_CRC_POLY;
            else c = c >> 1;
        end
    end
    return ~c;
endfunction

task automatic add_row(input string name, input int len, input fill_e fill, input bit corrupt,
                       input int uflow, input int ifg, input bit exp_user);
    tbl_name.push_back(name);
    tbl_len.push_back(len);
    tbl_fill.push_back(fill);
    tbl_corrupt.push_back(corrupt);
    tbl_uflow.push_back(uflow);
    tbl_ifg.push_back(ifg);
    tbl_user.push_back(exp_user);
endtask

task automatic clear_capture();
    tx_bytes.delete();
    rx_bytes.delete();
    start_cnt = 0;
    uflow_cnt = 0;
    tx_er_cnt = 0;
    rx_start_cnt = 0;
    bad_fcs_cnt = 0;
    bad_frame_cnt = 0;
    rx_done = 1'b0;
    rx_last_user = 1'b0;
    rx_last_valid = 1'b0;
endtask

// Underflow rows stop after uflow bytes and drop valid in DATA
task automatic send_frame(input int n, input int uflow);
    int idx;
    int stop;
    int cycles;
    idx = 0;
    cycles = 0;
    stop = (uflow > 0) ? uflow : n;
    while (idx < stop) begin
        s_axis_tx = '{tdata: payload[idx], tvalid: 1'b1, tlast: (idx == n - 1), tuser: 1'b0};
        @(negedge clk);
        if (s_axis_tx_ready) idx++;
        @(posedge clk);
        #1;
        cycles++;
        if (cycles > n + SEND_LIMIT) begin
            $display("Timeout in test %s: the framer stopped taking bytes at byte %0d",
                     row_name, idx);
            timeout_errors++;
            timed_out = 1'b1;
            break;
        end
    end
    s_axis_tx = '0;
endtask

task automatic wait_rx_done();
    int cycles;
    cycles = 0;
    while (!rx_done && !timed_out) begin
        @(posedge clk);
        cycles++;
        if (cycles > DONE_LIMIT) begin
            $display("Timeout in test %s: no last beat came back on the receive stream",
                     row_name);
            timeout_errors++;
            timed_out = 1'b1;
        end
    end
    #1;
endtask

// ########################################
// One table row
// ########################################

task automatic run_row(input int r);
    int n;
    logic [31:0] fcs;
    n = tbl_len[r];
    row_name = tbl_name[r];
    cfg_ifg = 8'(tbl_ifg[r]);
    payload.delete();
    for (int i = 0; i < n; i++) begin
        if (tbl_fill[r] == FILL_RAMP) payload.push_back(8'(i));
        else payload.push_back(8'($random(seed)));
    end
    clear_capture();
    corrupt_on = tbl_corrupt[r];
    send_frame(n, tbl_uflow[r]);
    wait_rx_done();
    if (timed_out) return;

    check_value("tx start pulses", 1, start_cnt);
    check_value("rx start pulses", 1, rx_start_cnt);
    check_value("last beat valid", 1, int'(rx_last_valid));
    check_value("last beat tuser", int'(tbl_user[r]), int'(rx_last_user));
    for (int i = 0; i < 8 && i < tx_bytes.size(); i++) begin
        check_value("preamble byte", (i == 7) ? 32'hD5 : 32'h55, int'(tx_bytes[i]));
    end
    if (tbl_uflow[r] > 0) begin
        check_value("underflow pulses", 1, uflow_cnt);
        check_value("tx error bytes", 1, tx_er_cnt);
        check_value("enable cycles", 8 + tbl_uflow[r] + 1, tx_bytes.size());
        check_value("bad frame pulses", 1, bad_frame_cnt);
        check_value("bad fcs pulses", 0, bad_fcs_cnt);
        return;
    end

    // Payload padded with zeros up to the minimum frame
    exp_q = payload;
    while (exp_q.size() < `ETH_MIN_FRAME_LEN - `ETH_FCS_LEN) exp_q.push_back(8'h00);
    check_value("underflow pulses", 0, uflow_cnt);
    check_value("tx error bytes", 0, tx_er_cnt);
    check_value("enable cycles", 8 + exp_q.size() + 4, tx_bytes.size());
    if (tx_bytes.size() >= 12) begin
        fcs = frame_crc(exp_q);
        for (int k = 0; k < 4; k++) begin
            check_value($sformatf("fcs byte %0d", k), int'(fcs[8*k +: 8]),
                        int'(tx_bytes[tx_bytes.size() - 4 + k]));
        end
    end
    if (tbl_corrupt[r]) exp_q[CORRUPT_POS] = exp_q[CORRUPT_POS] ^ CORRUPT_MASK;
    check_value("rx length", exp_q.size(), rx_bytes.size());
    for (int i = 0; i < exp_q.size() && i < rx_bytes.size(); i++) begin
        if (rx_bytes[i] != exp_q[i]) begin
            check_value($sformatf("rx byte %0d", i), int'(exp_q[i]), int'(rx_bytes[i]));
            break;
        end
    end
    check_value("bad frame pulses", 0, bad_frame_cnt);
    check_value("bad fcs pulses", int'(tbl_corrupt[r]), bad_fcs_cnt);
endtask

// ########################################
// Main sequence
// ########################################

initial begin
    seed = 32'h5a7466e3;
    rst = 1'b1;
    s_axis_tx = '0;
    cfg_ifg = 8'd12;
    row_name = "reset";

    //      name           len  fill         corrupt uflow ifg tuser
    add_row("pad_20",       20, FILL_RAMP,   1'b0,   0,    12, 1'b0);
    add_row("rand_100",    100, FILL_RANDOM, 1'b0,   0,    12, 1'b0);
    add_row("gap_20",       64, FILL_RAMP,   1'b0,   0,    20, 1'b0);
    add_row("exact_60",     60, FILL_RANDOM, 1'b0,   0,    12, 1'b0);
    add_row("bad_fcs",      80, FILL_RANDOM, 1'b1,   0,    12, 1'b1);
    add_row("underflow",    50, FILL_RAMP,   1'b0,   30,   12, 1'b1);
    add_row("after_uflow",  46, FILL_RANDOM, 1'b0,   0,    20, 1'b0);

    repeat (16) @(posedge clk);
    #1 rst = 1'b0;
    @(negedge clk);
    // Every output strobe and enable is idle out of reset
    check_value("idle outputs", 0, int'({gmii_tx.en, gmii_tx.er, s_axis_tx_ready,
                m_axis_rx.tvalid, rx_status, tx_start_packet, tx_error_underflow}));
    @(posedge clk);
    #1;

    for (int r = 0; r < tbl_name.size() && !timed_out; r++) begin
        run_row(r);
    end

    $display("Error counts: %0d value, %0d timeout", value_errors, timeout_errors);
    if (value_errors == 0 && timeout_errors == 0) begin
        $display("ALL TESTS PASSED");
    end else begin
        $display("SOME TESTS FAILED");
    end
    $finish;
end

endmodule

/* verilog/axis_pkg.sv */
// Host-side stream types; one byte per beat with no tkeep, tuser on the last beat flags a bad frame
`include "eth_mac_params.svh"
`default_nettype none

package axis_pkg;

    // Stream beat, tuser only meaningful together with tlast
    typedef struct packed {
        logic [`ETH_DATA_W-1:0] tdata;
        logic                   tvalid;
        logic                   tlast;
        logic                   tuser;
    } axis_beat_t;

    // Receive status, each bit a single-cycle pulse
    typedef struct packed {
        logic start_packet;
        logic error_bad_frame;
        logic error_bad_fcs;
    } rx_status_t;

endpackage

`resetall

/* verilog/eth_crc32.sv */
// Byte-wide reflected CRC-32; init wins over update, result is the raw register (not inverted)
`include "eth_mac_params.svh"
`default_nettype none

module eth_crc32 (
    input  wire logic                   clk,
    input  wire logic                   rst,
    input  wire logic                   init,
    input  wire logic                   update,
    input  wire logic [`ETH_DATA_W-1:0] data,
    output wire logic [31:0]            crc
);

logic [31:0] crc_q;

// Fold one byte into the running remainder, LSB first
function automatic logic [31:0] crc_next(input logic [31:0] cur, input logic [`ETH_DATA_W-1:0] d);
    logic [31:0] c;
    c = cur ^ {{(32-`ETH_DATA_W){1'b0}}, d};
    for (int i = 0; i < `ETH_DATA_W; i++) begin
        c = c[0] ? ((c >> 1) ^ `ETH_CRC_POLY) : (c >> 1);
    end
    return c;
endfunction

always_ff @(posedge clk) begin
    if (rst || init) begin
        crc_q <= '1;
    end else if (update) begin
        crc_q <= crc_next(crc_q, data);
    end
end

assign crc = crc_q;

endmodule

`resetall

/* verilog/eth_mac_1g.sv */
// 1G GMII MAC top; tx and rx clocks are separate but share one synchronous reset
`include "eth_mac_params.svh"
`default_nettype none

module eth_mac_1g
    import eth_pkg::*;
    import axis_pkg::*;
(
    input  wire logic                  tx_clk,
    input  wire logic                  rx_clk,
    input  wire logic                  rst,

    // Host stream
    input  wire axis_beat_t            s_axis_tx,
    output wire logic                  s_axis_tx_ready,
    output wire axis_beat_t            m_axis_rx,

    // GMII
    output wire gmii_t                 gmii_tx,
    input  wire gmii_t                 gmii_rx,

    // Configuration and status
    input  wire logic [`ETH_IFG_W-1:0] cfg_ifg,
    output wire logic                  tx_start_packet,
    output wire logic                  tx_error_underflow,
    output wire rx_status_t            rx_status
);

// Transmit path in the tx_clk domain
gmii_tx_framer tx_framer_i (
    .tx_clk(tx_clk),
    .rst(rst),
    .s_axis_tx(s_axis_tx),
    .s_axis_tx_ready(s_axis_tx_ready),
    .gmii_tx(gmii_tx),
    .cfg_ifg(cfg_ifg),
    .start_packet(tx_start_packet),
    .error_underflow(tx_error_underflow)
);

// Receive path in the rx_clk domain
gmii_rx_deframer rx_deframer_i (
    .rx_clk(rx_clk),
    .rst(rst),
    .gmii_rx(gmii_rx),
    .m_axis_rx(m_axis_rx),
    .rx_status(rx_status)
);

endmodule

`resetall

/* verilog/eth_pkg.sv */
// Line-side GMII types; the data field width follows ETH_DATA_W and assumes byte-wide GMII
`include "eth_mac_params.svh"
`default_nettype none

package eth_pkg;

    // ########################################
    // GMII byte
    // ########################################

    // One line-side byte per clock with its enable and error bits
    typedef struct packed {
        logic [`ETH_DATA_W-1:0] data;
        logic                   en;
        logic                   er;
    } gmii_t;

    // ########################################
    // State machines
    // ########################################

    // Transmit framer states
    typedef enum logic [2:0] {
        TX_IDLE,
        TX_PREAMBLE,
        TX_DATA,
        TX_PAD,
        TX_FCS,
        TX_IFG
    } tx_state_e;

    // Receive deframer states
    // DROP waits out a frame whose preamble was malformed
    typedef enum logic [1:0] {
        RX_IDLE,
        RX_PREAMBLE,
        RX_DATA,
        RX_DROP
    } rx_state_e;

endpackage

`resetall

/* verilog/gmii_rx_deframer.sv */
// GMII receive deframer; no back-pressure, frames under 5 bytes give status only and no beats
`include "eth_mac_params.svh"
`default_nettype none

module gmii_rx_deframer
    import eth_pkg::*;
    import axis_pkg::*;
(
    input  wire logic       rx_clk,
    input  wire logic       rst,
    input  wire gmii_t      gmii_rx,
    output wire axis_beat_t m_axis_rx,
    output wire rx_status_t rx_status
);

localparam int LEN_W = $clog2(`ETH_MIN_FRAME_LEN + 1);
localparam logic [LEN_W-1:0] MIN_LEN = LEN_W'(`ETH_MIN_FRAME_LEN);
localparam logic [LEN_W-1:0] DLY_LEN = LEN_W'(`ETH_FCS_LEN);

rx_state_e state_q;
logic [LEN_W-1:0] len_q;
logic er_seen_q;
logic pend_vld_q;
logic out_vld_q, out_last_q, out_user_q;
rx_status_t status_q;

// Delay line that ends up holding the FCS when the frame ends
logic [`ETH_FCS_LEN-1:0][`ETH_DATA_W-1:0] dly_q;
logic [`ETH_DATA_W-1:0] pend_q;
logic [`ETH_DATA_W-1:0] out_data_q;

logic [31:0] crc;
logic bad_frame, bad_fcs;

// FCS bytes are folded in as well, so a good frame leaves the residue
eth_crc32 crc_i (
    .clk(rx_clk),
    .rst(rst),
    .init(state_q != RX_DATA),
    .update(state_q == RX_DATA && gmii_rx.en),
    .data(gmii_rx.data),
    .crc(crc)
);

assign bad_frame = er_seen_q || (len_q < MIN_LEN);
assign bad_fcs = !bad_frame && (crc != `ETH_CRC_RESIDUE);

// ########################################
// Frame FSM and beat control
// ########################################

always_ff @(posedge rx_clk) begin
    if (rst) begin
        state_q <= RX_IDLE;
        len_q <= '0;
        er_seen_q <= 1'b0;
        pend_vld_q <= 1'b0;
        out_vld_q <= 1'b0;
        out_last_q <= 1'b0;
        out_user_q <= 1'b0;
        status_q <= '0;
    end else begin
        out_vld_q <= 1'b0;
        out_last_q <= 1'b0;
        out_user_q <= 1'b0;
        status_q <= '0;
        case (state_q)
            RX_IDLE: begin
                if (gmii_rx.en) begin
                    state_q <= (gmii_rx.data == `ETH_PREAMBLE_BYTE) ? RX_PREAMBLE : RX_DROP;
                end
            end
            RX_PREAMBLE: begin
                if (!gmii_rx.en) begin
                    state_q <= RX_IDLE;
                end else if (gmii_rx.data == `ETH_SFD_BYTE) begin
                    state_q <= RX_DATA;
                    len_q <= '0;
                    er_seen_q <= 1'b0;
                    pend_vld_q <= 1'b0;
                    status_q.start_packet <= 1'b1;
                end else if (gmii_rx.data != `ETH_PREAMBLE_BYTE) begin
                    state_q <= RX_DROP;
                end
            end
            RX_DATA: begin
                if (gmii_rx.en) begin
                    len_q <= (len_q < MIN_LEN) ? len_q + 1'b1 : len_q;
                    er_seen_q <= er_seen_q || gmii_rx.er;
                    // Held byte is released once a later byte proves it is not the last
                    if (len_q >= DLY_LEN) begin
                        pend_vld_q <= 1'b1;
                        out_vld_q <= pend_vld_q;
                    end
                end else begin
                    state_q <= RX_IDLE;
                    out_vld_q <= pend_vld_q;
                    out_last_q <= 1'b1;
                    out_user_q <= bad_frame || bad_fcs;
                    status_q.error_bad_frame <= bad_frame;
                    status_q.error_bad_fcs <= bad_fcs;
                end
            end
            RX_DROP: begin
                if (!gmii_rx.en) begin
                    state_q <= RX_IDLE;
                end
            end
            default: state_q <= RX_IDLE;
        endcase
    end
end

// Payload path
always_ff @(posedge rx_clk) begin
    if (state_q == RX_DATA && gmii_rx.en) begin
        dly_q <= {dly_q[`ETH_FCS_LEN-2:0], gmii_rx.data};
        pend_q <= dly_q[`ETH_FCS_LEN-1];
    end
    if (state_q == RX_DATA) begin
        out_data_q <= pend_q;
    end
end

assign m_axis_rx = '{tdata: out_data_q, tvalid: out_vld_q, tlast: out_last_q, tuser: out_user_q};
assign rx_status = status_q;

endmodule

`resetall

/* verilog/gmii_tx_framer.sv */
// GMII transmit framer; host must give one byte per cycle up to tlast, a gap is an underflow
`include "eth_mac_params.svh"
`default_nettype none

module gmii_tx_framer
    import eth_pkg::*;
    import axis_pkg::*;
(
    input  wire logic                  tx_clk,
    input  wire logic                  rst,
    input  wire axis_beat_t            s_axis_tx,
    output wire logic                  s_axis_tx_ready,
    output wire gmii_t                 gmii_tx,
    input  wire logic [`ETH_IFG_W-1:0] cfg_ifg,
    output wire logic                  start_packet,
    output wire logic                  error_underflow
);

localparam int CNT_W = `ETH_IFG_W;
localparam logic [CNT_W-1:0] MIN_PAYLOAD = CNT_W'(`ETH_MIN_FRAME_LEN - `ETH_FCS_LEN);
localparam logic [CNT_W-1:0] PRE_LAST = CNT_W'(`ETH_PREAMBLE_LEN);
localparam logic [CNT_W-1:0] FCS_LAST = CNT_W'(`ETH_FCS_LEN - 1);

tx_state_e state_q, state_d;
logic [CNT_W-1:0] cnt_q, cnt_d;
logic [`ETH_DATA_W-1:0] txd_q, txd_d;
logic en_q, en_d, er_q, er_d;
logic start_q, start_d, underflow_q, underflow_d;
logic [31:0] crc;
logic [31:0] fcs;
logic ifg_done;

// Pad bytes are zero and are covered by the FCS
eth_crc32 crc_i (
    .clk(tx_clk),
    .rst(rst),
    .init(state_q == TX_IDLE),
    .update((state_q == TX_DATA && s_axis_tx.tvalid) || state_q == TX_PAD),
    .data(state_q == TX_PAD ? '0 : s_axis_tx.tdata),
    .crc(crc)
);

assign fcs = ~crc;
assign ifg_done = (cfg_ifg == '0) || (cnt_q >= cfg_ifg - 1'b1);

// ########################################
// Next state and next wire byte
// ########################################

always_comb begin
    state_d = state_q;
    cnt_d = cnt_q;
    txd_d = '0;
    en_d = 1'b0;
    er_d = 1'b0;
    start_d = 1'b0;
    underflow_d = 1'b0;
    case (state_q)
        TX_IDLE: begin
            if (s_axis_tx.tvalid) begin
                state_d = TX_PREAMBLE;
                cnt_d = '0;
            end
        end
        TX_PREAMBLE: begin
            en_d = 1'b1;
            start_d = (cnt_q == '0);
            if (cnt_q == PRE_LAST) begin
                txd_d = `ETH_SFD_BYTE;
                state_d = TX_DATA;
                cnt_d = '0;
            end else begin
                txd_d = `ETH_PREAMBLE_BYTE;
                cnt_d = cnt_q + 1'b1;
            end
        end
        TX_DATA: begin
            en_d = 1'b1;
            if (s_axis_tx.tvalid) begin
                txd_d = s_axis_tx.tdata;
                // Count saturates once the minimum payload is reached
                cnt_d = (cnt_q < MIN_PAYLOAD) ? cnt_q + 1'b1 : cnt_q;
                if (s_axis_tx.tlast) begin
                    if (cnt_q + 1'b1 < MIN_PAYLOAD) begin
                        state_d = TX_PAD;
                    end else begin
                        state_d = TX_FCS;
                        cnt_d = '0;
                    end
                end
            end else begin
                // Host ran dry, abort without FCS
                er_d = 1'b1;
                underflow_d = 1'b1;
                state_d = TX_IFG;
                cnt_d = '0;
            end
        end
        TX_PAD: begin
            en_d = 1'b1;
            if (cnt_q + 1'b1 >= MIN_PAYLOAD) begin
                state_d = TX_FCS;
                cnt_d = '0;
            end else begin
                cnt_d = cnt_q + 1'b1;
            end
        end
        TX_FCS: begin
            en_d = 1'b1;
            txd_d = fcs[cnt_q[1:0]*`ETH_DATA_W +: `ETH_DATA_W];
            if (cnt_q == FCS_LAST) begin
                state_d = TX_IFG;
                cnt_d = '0;
            end else begin
                cnt_d = cnt_q + 1'b1;
            end
        end
        TX_IFG: begin
            if (ifg_done) begin
                state_d = TX_IDLE;
            end else begin
                cnt_d = cnt_q + 1'b1;
            end
        end
        default: state_d = TX_IDLE;
    endcase
end

always_ff @(posedge tx_clk) begin
    if (rst) begin
        state_q <= TX_IDLE;
        cnt_q <= '0;
        en_q <= 1'b0;
        er_q <= 1'b0;
        start_q <= 1'b0;
        underflow_q <= 1'b0;
    end else begin
        state_q <= state_d;
        cnt_q <= cnt_d;
        en_q <= en_d;
        er_q <= er_d;
        start_q <= start_d;
        underflow_q <= underflow_d;
    end
end

always_ff @(posedge tx_clk) begin
    txd_q <= txd_d;
end

assign s_axis_tx_ready = (state_q == TX_DATA);
assign gmii_tx = '{data: txd_q, en: en_q, er: er_q};
assign start_packet = start_q;
assign error_underflow = underflow_q;

endmodule

`resetall
